// File: files.f
verilog/histGeomPkg.sv
verilog/histCtrlPkg.sv
verilog/sampleDecode.sv
verilog/binAccumulate.sv
verilog/peakWindow.sv
verilog/histogramTop.sv
verif/histogramTb.sv

// File: run.sh
#!/bin/sh
# build and run the histogram testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f files.f --top-module histogramTb -o simv

# simulation output is kept in a variable and searched for the pass line
out=$(./obj_dir/simv)
echo "$out"
echo "$out" | grep -qx "NO ERRORS"

// File: verif/histogramTb.sv
`timescale 1ns/1ps

module histogramTb;

    localparam int PIXEL_NUM = histGeomPkg::PIXEL_NUM_DEF;
    localparam int DATA_NUM = histGeomPkg::DATA_NUM_DEF;
    localparam int ACQ_NUM = histGeomPkg::ACQ_NUM_DEF;
    localparam int NUM_FRAMES = 3;
    localparam int BIN_NUM = 1 << histGeomPkg::BIN_BITS;
    localparam int COUNT_MAX = (1 << histGeomPkg::COUNT_BITS) - 1;

    // one table row with stimulus and the model's count
    typedef struct packed {
        logic                  en;
        histGeomPkg::sampleT   data;
        histGeomPkg::binCountT expCount;
        logic                  last;
    } stimT;

    logic                  clk;
    logic                  combin_res;
    logic                  wrEn;
    histGeomPkg::sampleT   data;
    logic                  binValid;
    histGeomPkg::binCountT binCount;
    logic                  frameDone;
    logic                  peakValid;
    histGeomPkg::pixelIdxT peakPixel;
    histGeomPkg::sampleT   peakBin;
    histGeomPkg::binCountT peakCount;
    histCtrlPkg::finePosT  winLow;
    histCtrlPkg::finePosT  winHigh;

    stimT stimTbl[$];

    // expected peak per frame and pixel
    histGeomPkg::sampleT   frameBin [NUM_FRAMES][PIXEL_NUM];
    histGeomPkg::binCountT frameCnt [NUM_FRAMES][PIXEL_NUM];

    // pending results tagged with the cycle they are due in
    histGeomPkg::binCountT cntQ[$];
    int                    cntAt[$];
    int                    frameAt[$];
    histGeomPkg::pixelIdxT peakPixQ[$];
    histGeomPkg::sampleT   peakBinQ[$];
    histGeomPkg::binCountT peakCntQ[$];
    int                    peakAt[$];

    logic [7:0] lfsrState = 8'd59;
    int cycleCnt = 0;
    int timeoutLimit = 1000000;
    int testCnt = 0;
    int errCnt = 0;

    histogramTop #(
        .PIXEL_NUM(PIXEL_NUM),
        .DATA_NUM (DATA_NUM),
        .ACQ_NUM  (ACQ_NUM)
    ) dut0 (
        .clk       (clk),
        .combin_res(combin_res),
        .wrEn      (wrEn),
        .data      (data),
        .binValid  (binValid),
        .binCount  (binCount),
        .frameDone (frameDone),
        .peakValid (peakValid),
        .peakPixel (peakPixel),
        .peakBin   (peakBin),
        .peakCount (peakCount),
        .winLow    (winLow),
        .winHigh   (winHigh)
    );

    always #50 clk = ~clk;

    // galois lfsr with taps for x^8+x^6+x^5+x^4+1
    function automatic logic [7:0] lfsrNext(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic histGeomPkg::sampleT randomSample();
        histGeomPkg::sampleT v;
        v = '0;
        for (int b = 0; b < histGeomPkg::BIN_BITS; b++) begin
            v = histGeomPkg::sampleT'({v, lfsrState[0]});
            lfsrState = lfsrNext(lfsrState);
        end
        return v;
    endfunction

    // fixed patterns give bin 0 peaks, a tie, a bin 15 peak and a mid peak
    // frame 1 pixel 0 hits bin 0 so the clear before frame 2 shows up
    // everything else is random
    function automatic histGeomPkg::sampleT pickData(input int f, input int p, input int k);
        if (f == 0 && p == 0)
            return (k % 3 == 2) ? 4'd7 : 4'd0;
        if (f == 0 && p == 1)
            return (k == 0 || k == 3) ? 4'd9 : ((k < 3) ? 4'd5 : 4'd3);
        if (f == 0 && p == 2)
            return 4'd15;
        if (f == 1 && p == 0 && k == 0)
            return 4'd0;
        if (f == 2 && p == 0)
            return 4'd0;
        if (f == 2 && p == 3)
            return 4'd8;
        return randomSample();
    endfunction

    // idle lead-in and tail with an idle before every 7th strobe
    task automatic buildTable();
        stimT e;
        int n;
        n = 0;
        repeat (4) stimTbl.push_back('0);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            for (int a = 0; a < ACQ_NUM; a++) begin
                for (int p = 0; p < PIXEL_NUM; p++) begin
                    for (int s = 0; s < DATA_NUM; s++) begin
                        if (n % 7 == 3) begin
                            stimTbl.push_back('0);
                        end
                        e = '0;
                        e.en = 1'b1;
                        e.data = pickData(f, p, a * DATA_NUM + s);
                        stimTbl.push_back(e);
                        n++;
                    end
                end
            end
        end
        repeat (10) stimTbl.push_back('0);
    endtask

    // reference histograms and peak trackers over the whole table
    task automatic runModel();
        int hist [PIXEL_NUM][BIN_NUM];
        int maxC [PIXEL_NUM];
        histGeomPkg::sampleT maxB [PIXEL_NUM];
        int s;
        int p;
        int a;
        int f;
        int c;
        stimT e;
        s = 0;
        p = 0;
        a = 0;
        f = 0;
        for (int q = 0; q < PIXEL_NUM; q++) begin
            maxC[q] = 0;
            maxB[q] = '0;
            for (int b = 0; b < BIN_NUM; b++) begin
                hist[q][b] = 0;
            end
        end
        foreach (stimTbl[i]) begin
            e = stimTbl[i];
            if (e.en) begin
                c = (hist[p][e.data] < COUNT_MAX) ? hist[p][e.data] + 1 : COUNT_MAX;
                hist[p][e.data] = c;
                e.expCount = histGeomPkg::binCountT'(c);
                // only a strictly greater count moves the peak
                if (c > maxC[p]) begin
                    maxC[p] = c;
                    maxB[p] = e.data;
                end
                e.last = (s == DATA_NUM - 1) && (p == PIXEL_NUM - 1) && (a == ACQ_NUM - 1);
                s = (s == DATA_NUM - 1) ? 0 : s + 1;
                if (s == 0) begin
                    p = (p == PIXEL_NUM - 1) ? 0 : p + 1;
                    if (p == 0) begin
                        a = (a == ACQ_NUM - 1) ? 0 : a + 1;
                    end
                end
                if (e.last) begin
                    for (int q = 0; q < PIXEL_NUM; q++) begin
                        frameBin[f][q] = maxB[q];
                        frameCnt[f][q] = histGeomPkg::binCountT'(maxC[q]);
                        maxC[q] = 0;
                        maxB[q] = '0;
                        for (int b = 0; b < BIN_NUM; b++) begin
                            hist[q][b] = 0;
                        end
                    end
                    f++;
                end
                stimTbl[i] = e;
            end
        end
    endtask

    // window around the peak centre clamped to the fine range
    task automatic expectWindow(input histGeomPkg::sampleT b, output histCtrlPkg::finePosT lo,
                                output histCtrlPkg::finePosT hi);
        int centre;
        int half;
        int fineMax;
        half = histCtrlPkg::HALF_WINDOW;
        fineMax = (1 << histCtrlPkg::FINE_BITS) - 1;
        centre = int'(b) << histCtrlPkg::FINE_SHIFT;
        if (centre <= half) begin
            lo = '0;
            hi = histCtrlPkg::finePosT'(2 * half);
        end else if (centre >= fineMax - half) begin
            lo = histCtrlPkg::finePosT'(fineMax - 2 * half);
            hi = histCtrlPkg::finePosT'(fineMax);
        end else begin
            lo = histCtrlPkg::finePosT'(centre - half);
            hi = histCtrlPkg::finePosT'(centre + half);
        end
    endtask

    task automatic checkCount(input string name, input histGeomPkg::binCountT got,
                              input histGeomPkg::binCountT exp);
        testCnt++;
        if (got !== exp) begin
            errCnt++;
            $display("Fail %s got 0x%h expected 0x%h, cycle %0d", name, got, exp, cycleCnt);
        end else begin
            $display("ok   %s 0x%h, cycle %0d", name, got, cycleCnt);
        end
    endtask

    task automatic checkBin(input string name, input histGeomPkg::sampleT got,
                            input histGeomPkg::sampleT exp);
        testCnt++;
        if (got !== exp) begin
            errCnt++;
            $display("Fail %s got 0x%h expected 0x%h, cycle %0d", name, got, exp, cycleCnt);
        end else begin
            $display("ok   %s 0x%h, cycle %0d", name, got, cycleCnt);
        end
    endtask

    task automatic checkFine(input string name, input histCtrlPkg::finePosT got,
                             input histCtrlPkg::finePosT exp);
        testCnt++;
        if (got !== exp) begin
            errCnt++;
            $display("Fail %s got 0x%h expected 0x%h, cycle %0d", name, got, exp, cycleCnt);
        end else begin
            $display("ok   %s 0x%h, cycle %0d", name, got, cycleCnt);
        end
    endtask

    task automatic checkPixel(input string name, input histGeomPkg::pixelIdxT got,
                              input histGeomPkg::pixelIdxT exp);
        testCnt++;
        if (got !== exp) begin
            errCnt++;
            $display("Fail %s got 0x%h expected 0x%h, cycle %0d", name, got, exp, cycleCnt);
        end else begin
            $display("ok   %s 0x%h, cycle %0d", name, got, cycleCnt);
        end
    endtask

    task automatic reportProblem(input string what);
        errCnt++;
        $display("Error: %s, cycle %0d", what, cycleCnt);
    endtask

    // outputs are sampled on the falling edge
    always @(negedge clk) begin
        histGeomPkg::pixelIdxT pExp;
        histGeomPkg::sampleT   bExp;
        histGeomPkg::binCountT cExp;
        histCtrlPkg::finePosT  loExp;
        histCtrlPkg::finePosT  hiExp;
        cycleCnt++;
        if (cycleCnt > timeoutLimit) begin
            $display("timeout: the run did not finish within %0d cycles", timeoutLimit);
            $display("ERRORS FOUND");
            $finish;
        end else begin
            // per sample count
            if (cntAt.size() > 0 && cntAt[0] == cycleCnt) begin
                void'(cntAt.pop_front());
                cExp = cntQ.pop_front();
                if (!binValid) begin
                    reportProblem("binValid did not come for an accepted sample");
                end else begin
                    checkCount("binCount", binCount, cExp);
                end
            end else if (binValid) begin
                reportProblem("binValid came without a matching sample");
            end
            // end of frame pulse
            if (frameAt.size() > 0 && frameAt[0] == cycleCnt) begin
                void'(frameAt.pop_front());
                if (!frameDone) begin
                    reportProblem("frameDone missing after the last sample of a frame");
                end
            end else if (frameDone) begin
                reportProblem("frameDone pulsed outside a frame end");
            end
            // readout beats with one pixel per cycle
            if (peakAt.size() > 0 && peakAt[0] == cycleCnt) begin
                void'(peakAt.pop_front());
                pExp = peakPixQ.pop_front();
                bExp = peakBinQ.pop_front();
                cExp = peakCntQ.pop_front();
                if (!peakValid) begin
                    reportProblem("peakValid missing during a readout");
                end else begin
                    expectWindow(bExp, loExp, hiExp);
                    checkPixel("peakPixel", peakPixel, pExp);
                    checkBin("peakBin", peakBin, bExp);
                    checkCount("peakCount", peakCount, cExp);
                    checkFine("winLow", winLow, loExp);
                    checkFine("winHigh", winHigh, hiExp);
                end
            end else if (peakValid) begin
                reportProblem("peakValid high outside a readout");
            end
        end
    end

    initial begin
        int frameIdx;
        frameIdx = 0;
        clk = 1'b0;
        combin_res = 1'b0;
        wrEn = 1'b0;
        data = '0;
        buildTable();
        runModel();
        // limit covers reset and the table plus a pipeline margin
        timeoutLimit = stimTbl.size() + 3 + 50;
        repeat (3) @(posedge clk);
        combin_res <= 1'b1;
        foreach (stimTbl[i]) begin
            @(posedge clk);
            wrEn <= stimTbl[i].en;
            data <= stimTbl[i].data;
            // count due two edges after the sampling edge
            if (stimTbl[i].en) begin
                cntQ.push_back(stimTbl[i].expCount);
                cntAt.push_back(cycleCnt + 3);
            end
            // frame end and readout due one edge after the count
            if (stimTbl[i].last) begin
                frameAt.push_back(cycleCnt + 4);
                for (int p = 0; p < PIXEL_NUM; p++) begin
                    peakPixQ.push_back(histGeomPkg::pixelIdxT'(p));
                    peakBinQ.push_back(frameBin[frameIdx][p]);
                    peakCntQ.push_back(frameCnt[frameIdx][p]);
                    peakAt.push_back(cycleCnt + 4 + p);
                end
                frameIdx++;
            end
        end
        while (cntAt.size() > 0 || frameAt.size() > 0 || peakAt.size() > 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        $display("tests %0d, errors %0d", testCnt, errCnt);
        if (errCnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: verilog/histogramTop.sv
`timescale 1ns/1ps

module histogramTop #(
    parameter int PIXEL_NUM = histGeomPkg::PIXEL_NUM_DEF,
    parameter int DATA_NUM = histGeomPkg::DATA_NUM_DEF,
    parameter int ACQ_NUM = histGeomPkg::ACQ_NUM_DEF
) (
    input  logic                  clk,
    input  logic                  combin_res,
    input  logic                  wrEn,
    input  histGeomPkg::sampleT   data,
    output logic                  binValid,
    output histGeomPkg::binCountT binCount,
    output logic                  frameDone,
    output logic                  peakValid,
    output histGeomPkg::pixelIdxT peakPixel,
    output histGeomPkg::sampleT   peakBin,
    output histGeomPkg::binCountT peakCount,
    output histCtrlPkg::finePosT  winLow,
    output histCtrlPkg::finePosT  winHigh
);

    // decode to execute
    logic                  accEn;
    histGeomPkg::binAddrT  accAddr;
    histGeomPkg::pixelIdxT accPixel;
    histGeomPkg::sampleT   accBin;
    logic                  accLast;

    // execute to result
    logic                  cntValid;
    histGeomPkg::binCountT cntValue;
    histGeomPkg::pixelIdxT cntPixel;
    histGeomPkg::sampleT   cntBin;
    logic                  cntLast;

    // sample sequencing
    sampleDecode #(
        .PIXEL_NUM(PIXEL_NUM),
        .DATA_NUM (DATA_NUM),
        .ACQ_NUM  (ACQ_NUM)
    ) decode0 (
        .clk       (clk),
        .combin_res(combin_res),
        .wrEn      (wrEn),
        .data      (data),
        .accEn     (accEn),
        .accAddr   (accAddr),
        .accPixel  (accPixel),
        .accBin    (accBin),
        .accLast   (accLast)
    );

    // bin accumulation
    binAccumulate accum0 (
        .clk       (clk),
        .combin_res(combin_res),
        .accEn     (accEn),
        .accAddr   (accAddr),
        .accPixel  (accPixel),
        .accBin    (accBin),
        .accLast   (accLast),
        .cntValid  (cntValid),
        .cntValue  (cntValue),
        .cntPixel  (cntPixel),
        .cntBin    (cntBin),
        .cntLast   (cntLast)
    );

    // peak tracking and window readout
    peakWindow #(
        .PIXEL_NUM(PIXEL_NUM)
    ) result0 (
        .clk       (clk),
        .combin_res(combin_res),
        .cntValid  (cntValid),
        .cntValue  (cntValue),
        .cntPixel  (cntPixel),
        .cntBin    (cntBin),
        .cntLast   (cntLast),
        .frameDone (frameDone),
        .peakValid (peakValid),
        .peakPixel (peakPixel),
        .peakBin   (peakBin),
        .peakCount (peakCount),
        .winLow    (winLow),
        .winHigh   (winHigh)
    );

    // per sample count goes straight out
    assign binValid = cntValid;
    assign binCount = cntValue;

endmodule

// File: verilog/peakWindow.sv
`timescale 1ns/1ps

module peakWindow #(
    parameter int PIXEL_NUM = histGeomPkg::PIXEL_NUM_DEF
) (
    input  logic                  clk,
    input  logic                  combin_res,
    input  logic                  cntValid,
    input  histGeomPkg::binCountT cntValue,
    input  histGeomPkg::pixelIdxT cntPixel,
    input  histGeomPkg::sampleT   cntBin,
    input  logic                  cntLast,
    output logic                  frameDone,
    output logic                  peakValid,
    output histGeomPkg::pixelIdxT peakPixel,
    output histGeomPkg::sampleT   peakBin,
    output histGeomPkg::binCountT peakCount,
    output histCtrlPkg::finePosT  winLow,
    output histCtrlPkg::finePosT  winHigh
);

    // window constants in fine units
    localparam histCtrlPkg::finePosT HALF_WIN =
        histCtrlPkg::finePosT'(histCtrlPkg::HALF_WINDOW);
    localparam histCtrlPkg::finePosT FULL_WIN =
        histCtrlPkg::finePosT'(2 * histCtrlPkg::HALF_WINDOW);
    localparam histCtrlPkg::finePosT FINE_MAX = '1;

    // running maximum per pixel
    histGeomPkg::binCountT maxCount [PIXEL_NUM];
    histGeomPkg::sampleT   maxBin [PIXEL_NUM];

    // frame snapshot, read out while the next frame fills
    histGeomPkg::binCountT snapCount [PIXEL_NUM];
    histGeomPkg::sampleT   snapBin [PIXEL_NUM];

    histCtrlPkg::readoutStateT roState;
    histGeomPkg::pixelIdxT     roIdx;

    logic                 newMax;
    logic                 frameEnd;
    histCtrlPkg::finePosT peakCentre;

    // strictly greater, so ties keep the first bin
    assign newMax = cntValid && (cntValue > maxCount[cntPixel]);
    assign frameEnd = cntValid && cntLast;

    // tracker update, cleared once the frame is captured
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                maxCount[p] <= '0;
                maxBin[p] <= '0;
            end
        end else if (frameEnd) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                maxCount[p] <= '0;
                maxBin[p] <= '0;
            end
        end else if (newMax) begin
            maxCount[cntPixel] <= cntValue;
            maxBin[cntPixel] <= cntBin;
        end
    end

    // snapshot with the last sample folded in
    always_ff @(posedge clk) begin
        if (frameEnd) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                if (newMax && (cntPixel == histGeomPkg::pixelIdxT'(p))) begin
                    snapCount[p] <= cntValue;
                    snapBin[p] <= cntBin;
                end else begin
                    snapCount[p] <= maxCount[p];
                    snapBin[p] <= maxBin[p];
                end
            end
        end
    end

    // readout fsm, one pixel per cycle starting at pixel 0
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            roState <= histCtrlPkg::roIdle;
            roIdx <= '0;
            frameDone <= 1'b0;
        end else begin
            frameDone <= frameEnd;
            case (roState)
                histCtrlPkg::roIdle: begin
                    if (frameEnd) begin
                        roState <= histCtrlPkg::roStream;
                        roIdx <= '0;
                    end
                end
                histCtrlPkg::roStream: begin
                    if (roIdx == histGeomPkg::pixelIdxT'(PIXEL_NUM - 1)) begin
                        roState <= histCtrlPkg::roIdle;
                        roIdx <= '0;
                    end else begin
                        roIdx <= roIdx + 1'b1;
                    end
                end
                default: roState <= histCtrlPkg::roIdle;
            endcase
        end
    end

    assign peakValid = (roState == histCtrlPkg::roStream);
    assign peakPixel = roIdx;
    assign peakBin = snapBin[roIdx];
    assign peakCount = snapCount[roIdx];

    // centre of the peak bin on the fine grid
    assign peakCentre = histCtrlPkg::finePosT'(peakBin) << histCtrlPkg::FINE_SHIFT;

    // window bounds, clamped at both ends
    always_comb begin
        if (peakCentre <= HALF_WIN) begin
            winLow = '0;
            winHigh = FULL_WIN;
        end else if (peakCentre >= FINE_MAX - HALF_WIN) begin
            winHigh = FINE_MAX;
            winLow = FINE_MAX - FULL_WIN;
        end else begin
            winLow = peakCentre - HALF_WIN;
            winHigh = peakCentre + HALF_WIN;
        end
    end

endmodule

// File: verilog/binAccumulate.sv
`timescale 1ns/1ps

module binAccumulate (
    input  logic                  clk,
    input  logic                  combin_res,
    input  logic                  accEn,
    input  histGeomPkg::binAddrT  accAddr,
    input  histGeomPkg::pixelIdxT accPixel,
    input  histGeomPkg::sampleT   accBin,
    input  logic                  accLast,
    output logic                  cntValid,
    output histGeomPkg::binCountT cntValue,
    output histGeomPkg::pixelIdxT cntPixel,
    output histGeomPkg::sampleT   cntBin,
    output logic                  cntLast
);

    // one entry per address: every pixel gets a full set of bins
    localparam int MEM_DEPTH = 1 << $bits(histGeomPkg::binAddrT);

    histGeomPkg::binCountT countMem [MEM_DEPTH];

    // valid bit per bin
    // a clear bit means the stored count is stale, treat it as zero
    logic [MEM_DEPTH-1:0] validBits;

    histGeomPkg::binCountT storedCount;
    histGeomPkg::binCountT nextCount;

    // read side of the read-modify-write
    // write lands at the edge, so back to back hits see the new value
    assign storedCount = countMem[accAddr];

    always_comb begin
        if (!validBits[accAddr]) begin
            // first hit since the last clear
            nextCount = histGeomPkg::binCountT'(1);
        end else if (storedCount == '1) begin
            // saturate
            nextCount = storedCount;
        end else begin
            nextCount = storedCount + 1'b1;
        end
    end

    // count memory and result payload
    always_ff @(posedge clk) begin
        if (accEn) begin
            countMem[accAddr] <= nextCount;
            cntValue <= nextCount;
            cntPixel <= accPixel;
            cntBin <= accBin;
        end
    end

    // valid bits and strobes
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            validBits <= '0;
            cntValid <= 1'b0;
            cntLast <= 1'b0;
        end else begin
            cntValid <= accEn;
            cntLast <= accEn && accLast;
            // end of frame wipes every histogram in one edge
            if (accLast) begin
                validBits <= '0;
            end else if (accEn) begin
                validBits[accAddr] <= 1'b1;
            end
        end
    end

endmodule

// File: verilog/sampleDecode.sv
`timescale 1ns/1ps

module sampleDecode #(
    parameter int PIXEL_NUM = histGeomPkg::PIXEL_NUM_DEF,
    parameter int DATA_NUM = histGeomPkg::DATA_NUM_DEF,
    parameter int ACQ_NUM = histGeomPkg::ACQ_NUM_DEF
) (
    input  logic                  clk,
    input  logic                  combin_res,
    input  logic                  wrEn,
    input  histGeomPkg::sampleT   data,
    output logic                  accEn,
    output histGeomPkg::binAddrT  accAddr,
    output histGeomPkg::pixelIdxT accPixel,
    output histGeomPkg::sampleT   accBin,
    output logic                  accLast
);

    // counter widths, one spare value so a count of 1 still gets a bit
    localparam int SAMPLE_BITS = $clog2(DATA_NUM + 1);
    localparam int ACQ_BITS = $clog2(ACQ_NUM + 1);

    logic [SAMPLE_BITS-1:0] sampleCnt;
    histGeomPkg::pixelIdxT  pixelCnt;
    logic [ACQ_BITS-1:0]    acqCnt;

    // wrap flags for each level
    logic sampleWrap;
    logic pixelWrap;
    logic acqWrap;

    assign sampleWrap = (sampleCnt == SAMPLE_BITS'(DATA_NUM - 1));
    assign pixelWrap = (pixelCnt == histGeomPkg::pixelIdxT'(PIXEL_NUM - 1));
    assign acqWrap = (acqCnt == ACQ_BITS'(ACQ_NUM - 1));

    // three level counting: sample, then pixel, then acquisition
    // only a strobe moves anything, idle cycles hold the position
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixelCnt <= '0;
            acqCnt <= '0;
            accEn <= 1'b0;
            accLast <= 1'b0;
        end else begin
            accEn <= wrEn;
            // final sample of the frame, all three at max
            accLast <= wrEn && sampleWrap && pixelWrap && acqWrap;
            if (wrEn) begin
                if (!sampleWrap) begin
                    sampleCnt <= sampleCnt + 1'b1;
                end else begin
                    sampleCnt <= '0;
                    if (!pixelWrap) begin
                        pixelCnt <= pixelCnt + 1'b1;
                    end else begin
                        pixelCnt <= '0;
                        acqCnt <= acqWrap ? '0 : acqCnt + 1'b1;
                    end
                end
            end
        end
    end

    // address forming, pixel above bin
    always_ff @(posedge clk) begin
        if (wrEn) begin
            accAddr <= {pixelCnt, data};
            accPixel <= pixelCnt;
            accBin <= data;
        end
    end

endmodule

// File: verilog/histCtrlPkg.sv
package histCtrlPkg;

    // fine resolution position width
    localparam int FINE_BITS = 8;

    // bin index to fine position scaling
    localparam int FINE_SHIFT = FINE_BITS - histGeomPkg::BIN_BITS;

    // half the window width, in fine units
    localparam int HALF_WINDOW = 8;

    // fine position, window bounds
    typedef logic [FINE_BITS-1:0] finePosT;

    // readout stream fsm
    typedef enum logic {
        roIdle,
        roStream
    } readoutStateT;

endpackage

// File: verilog/histGeomPkg.sv
package histGeomPkg;

    // width of one incoming sample
    // the sample value doubles as the bin index
    localparam int BIN_BITS = 4;

    // one bin count, saturates at all ones
    localparam int COUNT_BITS = 8;

    // default frame geometry, overridden from the top level
    localparam int PIXEL_NUM_DEF = 4;
    localparam int DATA_NUM_DEF = 3;
    localparam int ACQ_NUM_DEF = 2;

    // pixel index width, must cover PIXEL_NUM
    localparam int PIXEL_BITS = 2;

    // sample value and bin index
    typedef logic [BIN_BITS-1:0] sampleT;

    // single histogram bin count
    typedef logic [COUNT_BITS-1:0] binCountT;

    // pixel number inside a frame
    typedef logic [PIXEL_BITS-1:0] pixelIdxT;

    // count memory address
    // pixel index on top, bin index below
    typedef logic [PIXEL_BITS+BIN_BITS-1:0] binAddrT;

endpackage
